//--- iec_golden.txt
# F sel | W sel addr data | C mode0 mode1 rst0 rst1 atn pause
# S data clk led | H cycles data clk led | K steps    (all values hex)
F 0
F 1
W 0 00 81
W 0 01 02
W 0 02 83
W 0 03 00
W 1 00 03
W 1 01 01
W 1 02 82
W 1 03 07
K 1
C 0 1 0 1 0 0
S 1 0 1
S 0 1 0
S 1 1 1
S 0 0 0
S 0 0 0
C 0 1 0 0 0 0
S 1 0 0
S 0 0 0
S 0 1 2
S 0 0 0
C 0 1 1 0 0 0
S 0 0 0
C 0 1 0 0 0 0
S 1 0 1
S 0 1 0
C 0 1 0 1 1 0
S 1 1 1
S 0 0 0
S 0 0 0
S 0 0 0
C 0 1 0 1 0 0
S 0 0 0
S 1 0 0
C 0 1 0 1 0 1
H 30 1 0 0
C 0 1 0 1 0 0
S 0 1 0
S 1 1 0
K 38
S 1 0 1
S 0 1 0

//--- filelist.f
iec_multi_pkg.sv
iec_drive_if.sv
drive_phase_gen.sv
rom_bank.sv
rom_slot_arb.sv
drive_core.sv
iec_bus_merge.sv
iec_multi_drive.sv
tb_clk_gen.sv
iec_multi_drive_assertions.sv
tb_iec_multi_drive.sv

//--- Makefile
TOP = tb_iec_multi_drive

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_iec_multi_drive.sv
//----------------------------------------
// testbench for the multi-drive subsystem
// replays the golden records and checks the bus
//----------------------------------------
`timescale 1ns/1ps

module tb_iec_multi_drive;

	import iec_multi_pkg::*;

	localparam int NDRIVES = 2;
	localparam int ROM_AW  = 8;
	localparam int MAXREC  = 128;

	logic               clk;
	logic               rst_n;
	logic               ce;
	logic               pause;
	logic               atn;
	logic               ext_data;
	logic               ext_clk;
	logic [NDRIVES-1:0] drv_reset;
	logic [MODEL_W-1:0] drv_mode [NDRIVES];
	logic [MODEL_W-1:0] rom_sel;
	logic [ROM_AW-1:0]  rom_addr;
	logic [7:0]         rom_data;
	logic               rom_wr;
	logic               iec_data;
	logic               iec_clk;
	logic [NDRIVES-1:0] led;

	byte rec_kind [MAXREC];
	int  rec_arg [MAXREC][6];
	int  nrec;
	int  errors;
	int  nchecks;
	int  limit;

	tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

	iec_multi_drive #(.NDRIVES(NDRIVES), .ROM_AW(ROM_AW)) dut_i (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.ce_i        (ce),
		.pause_i     (pause),
		.drv_reset_i (drv_reset),
		.drv_mode_i  (drv_mode),
		.rom_sel_i   (rom_sel),
		.rom_addr_i  (rom_addr),
		.rom_data_i  (rom_data),
		.rom_wr_i    (rom_wr),
		.iec_atn_i   (atn),
		.iec_data_i  (ext_data),
		.iec_clk_i   (ext_clk),
		.iec_data_o  (iec_data),
		.iec_clk_o   (iec_clk),
		.led_o       (led)
	);

	function automatic int arg_count(input byte kind);
		case (kind)
			"W": return 3;
			"C": return 6;
			"S": return 3;
			"H": return 4;
			default: return 1;
		endcase
	endfunction

	task automatic load_golden();
		int    fd;
		int    v;
		string tok;
		string line;
		fd   = $fopen("iec_golden.txt", "r");
		nrec = 0;
		if (fd == 0) begin
			$display("Cannot open the golden file iec_golden.txt");
			errors++;
			return;
		end
		while (nrec < MAXREC) begin
			if ($fscanf(fd, "%s", tok) != 1) break;
			if (tok.getc(0) == "#") begin
				void'($fgets(line, fd));
				continue;
			end
			rec_kind[nrec] = tok.getc(0);
			for (int j = 0; j < arg_count(rec_kind[nrec]); j++) begin
				void'($fscanf(fd, "%h", v));
				rec_arg[nrec][j] = v;
			end
			nrec++;
		end
		$fclose(fd);
	endtask

	task automatic check_line(input string name, input logic exp, input logic got);
		nchecks++;
		if (got !== exp) begin
			$display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
			errors++;
		end
	endtask

	task automatic check_leds(input logic [NDRIVES-1:0] exp, input logic [NDRIVES-1:0] got);
		nchecks++;
		if (got !== exp) begin
			$display("Fail led_o: expected %h, got %h at %0t", exp, got, $time);
			errors++;
		end
	endtask

	// called at 1 ns past an edge, leaves the same way
	task automatic rom_write(input int sel, input int addr, input int data);
		rom_sel  = MODEL_W'(sel);
		rom_addr = ROM_AW'(addr);
		rom_data = 8'(data);
		rom_wr   = 1'b1;
		@(posedge clk);
		#1 rom_wr = 1'b0;
	endtask

	// next n steps, then to the sample point 8 cycles on
	task automatic wait_steps(input int n);
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
			while (dut_i.ph2_f1 !== 1'b1) @(posedge clk);
		end
		repeat (8) @(posedge clk);
	endtask

	task automatic check_outputs(input int r, input int base);
		check_line("iec_data_o", 1'(rec_arg[r][base]), iec_data);
		check_line("iec_clk_o", 1'(rec_arg[r][base + 1]), iec_clk);
		check_leds(NDRIVES'(rec_arg[r][base + 2]), led);
	endtask

	initial begin
		ce          = 1'b1;
		pause       = 1'b0;
		atn         = 1'b0;
		ext_data    = 1'b1;
		ext_clk     = 1'b1;
		drv_reset   = '1;
		drv_mode[0] = '0;
		drv_mode[1] = '0;
		rom_sel     = '0;
		rom_addr    = '0;
		rom_data    = '0;
		rom_wr      = 1'b0;
		errors      = 0;
		nchecks     = 0;
		load_golden();

		limit = 200;
		for (int i = 0; i < nrec; i++) begin
			case (rec_kind[i])
				"F": limit += 2**ROM_AW;
				"W": limit += 1;
				"S": limit += 16;
				"H": limit += rec_arg[i][0];
				"K": limit += 16 * rec_arg[i][0];
				default: ;
			endcase
		end

		fork
			begin
				repeat (limit) @(posedge clk);
				$display("Timeout: no finish within %0d cycles", limit);
				$display("Simulation finished: FAIL");
				$finish;
			end
		join_none

		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		for (int i = 0; i < nrec; i++) begin
			case (rec_kind[i])
				"F": begin
					// fill byte is the address itself
					for (int a = 0; a < 2**ROM_AW; a++) begin
						rom_write(rec_arg[i][0], a, a);
					end
				end
				"W": rom_write(rec_arg[i][0], rec_arg[i][1], rec_arg[i][2]);
				"C": begin
					drv_mode[0]  = MODEL_W'(rec_arg[i][0]);
					drv_mode[1]  = MODEL_W'(rec_arg[i][1]);
					drv_reset[0] = 1'(rec_arg[i][2]);
					drv_reset[1] = 1'(rec_arg[i][3]);
					atn          = 1'(rec_arg[i][4]);
					pause        = 1'(rec_arg[i][5]);
				end
				"S": begin
					wait_steps(1);
					check_outputs(i, 0);
					#1;
				end
				"H": begin
					repeat (rec_arg[i][0]) @(posedge clk);
					check_outputs(i, 1);
					#1;
				end
				"K": begin
					wait_steps(rec_arg[i][0]);
					#1;
				end
				default: begin
					$display("Unknown record kind in the golden file");
					errors++;
				end
			endcase
		end

		$display("Checks: %0d, errors: %0d", nchecks, errors);
		if (errors == 0 && nchecks > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- iec_multi_drive_assertions.sv
//----------------------------------------
// bound checks on the multi-drive top level
//----------------------------------------
`timescale 1ns/1ps

module iec_multi_drive_assertions #(
	parameter int NDR = 2
) (
	input logic           clk,
	input logic           rst_n_i,
	input logic           ph2_f1,
	input logic [NDR-1:0] drv_reset_i,
	input logic           iec_data_o,
	input logic           iec_clk_o,
	input logic [NDR-1:0] led_o
);

	logic [NDR-1:0] rst_prev;
	logic [2:0]     rst_age;

	// cycles since the drive resets last changed
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rst_prev <= '1;
			rst_age  <= '0;
		end else begin
			rst_prev <= drv_reset_i;
			if (drv_reset_i != rst_prev) begin
				rst_age <= '0;
			end else if (rst_age != 3'd7) begin
				rst_age <= rst_age + 3'd1;
			end
		end
	end

	for (genvar i = 0; i < NDR; i++) begin : g_led
		led_off_in_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
			(drv_reset_i[i] && $past(drv_reset_i[i]) && $past(drv_reset_i[i], 2)
				&& $past(drv_reset_i[i], 3)) |-> !led_o[i])
			else $error("led of drive %0d lit while held in reset", i);
	end

	data_released_all_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
		((&drv_reset_i) && $past(&drv_reset_i) && $past(&drv_reset_i, 2)) |-> iec_data_o)
		else $error("data line pulled with every drive in reset");

	// only a step or a reset change may move the outputs
	stable_between_steps: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!$past(ph2_f1) && rst_age > 3'd3)
			|-> ($stable(iec_data_o) && $stable(iec_clk_o) && $stable(led_o)))
		else $error("bus outputs changed between steps");

endmodule

bind iec_multi_drive iec_multi_drive_assertions #(.NDR(NDR)) u_assert (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.ph2_f1      (ph2_f1),
	.drv_reset_i (drv_reset_i),
	.iec_data_o  (iec_data_o),
	.iec_clk_o   (iec_clk_o),
	.led_o       (led_o)
);

//--- tb_clk_gen.sv
//----------------------------------------
// testbench clock and reset source
//----------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RST_CYCLES  = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// reset released just after a rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

//--- iec_multi_drive.sv
//----------------------------------------
// multi-drive subsystem, shared rom bank
//----------------------------------------
`timescale 1ns/1ps

module iec_multi_drive #(
	parameter int NDRIVES = 2,
	parameter int ROM_AW  = 15,
	localparam int NDR    = (NDRIVES < 1) ? 1 : (NDRIVES > 4) ? 4 : NDRIVES
) (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              ce_i,
	input  logic                              pause_i,
	input  logic [NDR-1:0]                    drv_reset_i,
	input  logic [iec_multi_pkg::MODEL_W-1:0] drv_mode_i [NDR],
	input  logic [iec_multi_pkg::MODEL_W-1:0] rom_sel_i,
	input  logic [ROM_AW-1:0]                 rom_addr_i,
	input  logic [7:0]                        rom_data_i,
	input  logic                              rom_wr_i,
	input  logic                              iec_atn_i,
	input  logic                              iec_data_i,
	input  logic                              iec_clk_i,
	output logic                              iec_data_o,
	output logic                              iec_clk_o,
	output logic [NDR-1:0]                    led_o
);

	import iec_multi_pkg::*;

	logic              ph2_f1;
	logic              ph2_f2;
	logic [ROM_AW-1:0] rd_addr;
	logic [7:0]        rd_data [NMODELS];
	rom_size_e         rom_size [NMODELS];
	logic [ROM_AW-1:0] drv_addr [NDR];
	logic [7:0]        drv_data [NDR];

	iec_drive_if drv_bus [NDR] ();

	drive_phase_gen u_phase (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.ce_i     (ce_i),
		.pause_i  (pause_i),
		.ph2_f1_o (ph2_f1),
		.ph2_f2_o (ph2_f2)
	);

	rom_bank #(.ROM_AW(ROM_AW)) u_rom (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_sel_i  (rom_sel_i),
		.rom_addr_i (rom_addr_i),
		.rom_data_i (rom_data_i),
		.rom_wr_i   (rom_wr_i),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data),
		.rom_size_o (rom_size)
	);

	rom_slot_arb #(.NDRIVES(NDR), .ROM_AW(ROM_AW)) u_arb (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ph2_f2_i   (ph2_f2),
		.drv_mode_i (drv_mode_i),
		.drv_addr_i (drv_addr),
		.rom_size_i (rom_size),
		.rd_addr_o  (rd_addr),
		.rd_data_i  (rd_data),
		.drv_data_o (drv_data)
	);

	iec_bus_merge #(.NDRIVES(NDR)) u_merge (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.drv_reset_i (drv_reset_i),
		.iec_atn_i   (iec_atn_i),
		.iec_data_i  (iec_data_i),
		.iec_clk_i   (iec_clk_i),
		.iec_data_o  (iec_data_o),
		.iec_clk_o   (iec_clk_o),
		.bus         (drv_bus)
	);

	for (genvar i = 0; i < NDR; i++) begin : g_drive
		drive_core #(.ROM_AW(ROM_AW)) u_core (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.ph2_f1_i   (ph2_f1),
			.bus        (drv_bus[i]),
			.rom_addr_o (drv_addr[i]),
			.rom_data_i (drv_data[i]),
			.led_o      (led_o[i])
		);
	end

endmodule

//--- iec_bus_merge.sv
//----------------------------------------
// bus merger, input sync and wired-AND
// drives in reset count as released
//----------------------------------------
`timescale 1ns/1ps

module iec_bus_merge #(
	parameter int NDRIVES = 2
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic [NDRIVES-1:0] drv_reset_i,
	input  logic               iec_atn_i,
	input  logic               iec_data_i,
	input  logic               iec_clk_i,
	output logic               iec_data_o,
	output logic               iec_clk_o,
	iec_drive_if.bus           bus [NDRIVES]
);

	logic [1:0]         atn_s, data_s, clk_s;
	logic [NDRIVES-1:0] rst_s1, rst_s2;
	logic [NDRIVES-1:0] data_d, clk_d;

	// two-flop syncs with the bus idle released and the drives in reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			atn_s  <= 2'b11;
			data_s <= 2'b11;
			clk_s  <= 2'b11;
			rst_s1 <= '1;
			rst_s2 <= '1;
		end else begin
			atn_s  <= {atn_s[0], iec_atn_i};
			data_s <= {data_s[0], iec_data_i};
			clk_s  <= {clk_s[0], iec_clk_i};
			rst_s1 <= drv_reset_i;
			rst_s2 <= rst_s1;
		end
	end

	for (genvar i = 0; i < NDRIVES; i++) begin : g_drv
		assign data_d[i]      = bus[i].data_out | rst_s2[i];
		assign clk_d[i]       = bus[i].clk_out | rst_s2[i];
		assign bus[i].atn     = atn_s[1];
		assign bus[i].data_in = data_s[1] & iec_data_o;
		assign bus[i].clk_in  = clk_s[1] & iec_clk_o;
		assign bus[i].reset   = rst_s2[i];
	end

	assign iec_data_o = &data_d;
	assign iec_clk_o  = &clk_d;

endmodule

//--- drive_core.sv
//----------------------------------------
// drive core, rom-driven command sequencer
// one command byte per 1 MHz step
//----------------------------------------
`timescale 1ns/1ps

module drive_core #(
	parameter int ROM_AW = 15
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    ph2_f1_i,
	iec_drive_if.drive              bus,
	output logic [ROM_AW-1:0]       rom_addr_o,
	input  iec_multi_pkg::rom_cmd_u rom_data_i,
	output logic                    led_o
);

	logic [ROM_AW-1:0] ptr_q;
	logic              data_q;
	logic              clk_q;
	logic              led_q;
	logic              stall;

	// wait here while the host keeps atn released
	assign stall = rom_data_i.cmd.atn_wait & bus.atn;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ptr_q  <= '0;
			data_q <= 1'b1;
			clk_q  <= 1'b1;
			led_q  <= 1'b0;
		end else if (bus.reset) begin
			// release the lines and restart from address 0
			ptr_q  <= '0;
			data_q <= 1'b1;
			clk_q  <= 1'b1;
			led_q  <= 1'b0;
		end else if (ph2_f1_i) begin
			data_q <= rom_data_i.cmd.data_rel;
			clk_q  <= rom_data_i.cmd.clk_rel;
			led_q  <= rom_data_i.cmd.led;
			if (!stall) begin
				ptr_q <= ptr_q + ROM_AW'(1);
			end
		end
	end

	assign rom_addr_o   = ptr_q;
	assign bus.data_out = data_q;
	assign bus.clk_out  = clk_q;
	assign led_o        = led_q;

endmodule

//--- rom_slot_arb.sv
//----------------------------------------
// rom slot sequencer
// shares one read port among the drives
//----------------------------------------
`timescale 1ns/1ps

module rom_slot_arb #(
	parameter int NDRIVES = 2,
	parameter int ROM_AW  = 15
) (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              ph2_f2_i,
	input  logic [iec_multi_pkg::MODEL_W-1:0] drv_mode_i [NDRIVES],
	input  logic [ROM_AW-1:0]                 drv_addr_i [NDRIVES],
	input  iec_multi_pkg::rom_size_e          rom_size_i [iec_multi_pkg::NMODELS],
	output logic [ROM_AW-1:0]                 rd_addr_o,
	input  logic [7:0]                        rd_data_i [iec_multi_pkg::NMODELS],
	output logic [7:0]                        drv_data_o [NDRIVES]
);

	logic [2:0]        slot_q;
	logic [ROM_AW-1:0] masked [NDRIVES];

	// top two bits limited by the model's rom size
	for (genvar i = 0; i < NDRIVES; i++) begin : g_mask
		assign masked[i] = {drv_addr_i[i][ROM_AW-1 -: 2] & rom_size_i[drv_mode_i[i]],
			drv_addr_i[i][ROM_AW-3:0]};
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			slot_q    <= '0;
			rd_addr_o <= '0;
			for (int i = 0; i < NDRIVES; i++) begin
				drv_data_o[i] <= '0;
			end
		end else begin
			// restart every 2 MHz period, park on the last slot
			if (ph2_f2_i) begin
				slot_q <= '0;
			end else if (slot_q != 3'd7) begin
				slot_q <= slot_q + 3'd1;
			end

			// address out in slot i, data back three slots later
			for (int i = 0; i < NDRIVES; i++) begin
				if (slot_q == 3'(i)) begin
					rd_addr_o <= masked[i];
				end
				if (slot_q == 3'(i + 3)) begin
					drv_data_o[i] <= rd_data_i[drv_mode_i[i]];
				end
			end
		end
	end

endmodule

//--- rom_bank.sv
//----------------------------------------
// firmware rom bank, one memory per model
// upload port plus size detection
//----------------------------------------
`timescale 1ns/1ps

module rom_bank #(
	parameter int ROM_AW = 15
) (
	input  logic                               clk,
	input  logic                               rst_n_i,
	input  logic [iec_multi_pkg::MODEL_W-1:0]  rom_sel_i,
	input  logic [ROM_AW-1:0]                  rom_addr_i,
	input  logic [7:0]                         rom_data_i,
	input  logic                               rom_wr_i,
	input  logic [ROM_AW-1:0]                  rd_addr_i,
	output logic [7:0]                         rd_data_o [iec_multi_pkg::NMODELS],
	output iec_multi_pkg::rom_size_e           rom_size_o [iec_multi_pkg::NMODELS]
);

	import iec_multi_pkg::*;

	rom_cmd_u wr_byte;
	logic     wr_used;

	assign wr_byte.raw = rom_data_i;

	// 00 and ff count as empty fill
	assign wr_used = rom_wr_i & (|wr_byte.raw) & ~(&wr_byte.raw);

	//----------------------------------------
	// memories
	//----------------------------------------
	for (genvar m = 0; m < NMODELS; m++) begin : g_model
		logic [7:0] mem [2**ROM_AW];
		logic [7:0] rd_q;

		always_ff @(posedge clk) begin
			if (rom_wr_i && (rom_sel_i == MODEL_W'(m))) begin
				mem[rom_addr_i] <= rom_data_i;
			end
			rd_q <= mem[rd_addr_i];
		end

		// second read stage
		always_ff @(posedge clk or negedge rst_n_i) begin
			if (!rst_n_i) begin
				rd_data_o[m] <= '0;
			end else begin
				rd_data_o[m] <= rd_q;
			end
		end
	end

	//----------------------------------------
	// size detection
	//----------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int m = 0; m < NMODELS; m++) begin
				rom_size_o[m] <= SIZE_FULL;
			end
		end else if (wr_used) begin
			// last non-empty write sets the mask
			rom_size_o[rom_sel_i] <= rom_size_e'({rom_addr_i[ROM_AW-1],
				rom_addr_i[ROM_AW-1] | rom_addr_i[ROM_AW-2]});
		end
	end

endmodule

//--- drive_phase_gen.sv
//----------------------------------------
// drive phase enables
// 1 MHz and 2 MHz steps from the 16 MHz ce
//----------------------------------------
`timescale 1ns/1ps

module drive_phase_gen (
	input  logic clk,
	input  logic rst_n_i,
	input  logic ce_i,
	input  logic pause_i,
	output logic ph2_f1_o,
	output logic ph2_f2_o
);

	logic [3:0] div_q;
	logic [1:0] pause_q;
	logic       run;

	// pause takes effect two cycles late
	assign run = ~pause_q[1];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			div_q    <= '0;
			pause_q  <= '0;
			ph2_f1_o <= 1'b0;
			ph2_f2_o <= 1'b0;
		end else begin
			pause_q  <= {pause_q[0], pause_i};
			ph2_f1_o <= ce_i & run & (div_q == 4'd7);
			ph2_f2_o <= ce_i & run & (div_q[2:0] == 3'd7);
			if (ce_i) begin
				div_q <= div_q + 4'd1;
			end
		end
	end

endmodule

//--- iec_drive_if.sv
//----------------------------------------
// one drive's view of the serial bus
//----------------------------------------
`timescale 1ns/1ps

interface iec_drive_if;

	// merged bus towards the drive
	logic atn;
	logic data_in;
	logic clk_in;
	logic reset;

	// drive's own line levels where 1 is released
	logic data_out;
	logic clk_out;

	modport bus (output atn, output data_in, output clk_in, output reset,
		input data_out, input clk_out);

	modport drive (input atn, input data_in, input clk_in, input reset,
		output data_out, output clk_out);

endinterface

//--- iec_multi_pkg.sv
//----------------------------------------
// iec multi-drive shared definitions
// model count, command byte layout, rom size codes
//----------------------------------------
package iec_multi_pkg;

	// drive models sharing the rom bank
	localparam int NMODELS = 2;
	localparam int MODEL_W = 1;

	// command view of one rom byte
	typedef struct packed {
		logic       led;
		logic [3:0] reserved;
		logic       atn_wait;
		logic       clk_rel;
		logic       data_rel;
	} rom_cmd_t;

	// the same byte seen raw or decoded
	typedef union packed {
		logic [7:0] raw;
		rom_cmd_t   cmd;
	} rom_cmd_u;

	// mask for the two top address bits
	typedef enum logic [1:0] {
		SIZE_QUARTER = 2'b00,
		SIZE_HALF    = 2'b01,
		SIZE_FULL    = 2'b11
	} rom_size_e;

endpackage
